/* cpu_pkg.sv */
package cpu_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int INST_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int IMM_WIDTH      = 16;
  localparam int ADDR_WIDTH     = 16;
  localparam int NUM_REGS       = 2 ** REG_ADDR_WIDTH;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [INST_WIDTH-1:0]     inst_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [IMM_WIDTH-1:0]      imm_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;

  // opcode lives in bits 31:26
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_SLT  = 6'd5,
    OP_ADDI = 6'd6,
    OP_ORI  = 6'd7,
    OP_LW   = 6'd8,
    OP_SW   = 6'd9
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_RF,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////////////////////////////////////////

  // all zero is a nop
  typedef struct packed {
    logic    reg_dst;
    logic    alu_src;
    alu_op_e alu_op;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    data_t     read_data_1;
    data_t     read_data_2;
    imm_t      imm;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    data_t     alu_result;
    data_t     store_data;
    reg_addr_t dst;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    data_t     data;
  } wb_t;

  // every real instruction reads rs
  function automatic logic uses_rs(ctrl_t c);
    return c.reg_write | c.mem_write;
  endfunction

  // r-type ops and stores read rt
  function automatic logic uses_rt(ctrl_t c);
    return c.reg_dst | c.mem_write;
  endfunction

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
  parameter int IMEM_DEPTH_LOG2 = 6
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            run,
  input  logic            stall,
  input  logic            imem_we,
  input  cpu_pkg::addr_t  imem_addr,
  input  cpu_pkg::inst_t  imem_data,
  output cpu_pkg::inst_t  if_id_inst
);

  import cpu_pkg::*;

  localparam int IMEM_DEPTH = 2 ** IMEM_DEPTH_LOG2;

  inst_t imem [IMEM_DEPTH];
  addr_t pc;
  inst_t fetched;

  // loaded only while run is low
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[IMEM_DEPTH_LOG2-1:0]] <= imem_data;
    end
  end

  // address wraps at the memory depth
  assign fetched = imem[pc[IMEM_DEPTH_LOG2-1:0]];

  ////////////////////////////////////////////////////////////////////////////
  // pc and if/id
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (run && !stall) begin
      pc <= pc + addr_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if_id_inst <= '0;
    end else if (!run) begin
      if_id_inst <= '0;
    end else if (!stall) begin
      if_id_inst <= fetched;
    end
  end

  // program load and execution never overlap
  a_no_load_while_run: assert property (
    @(posedge clk) disable iff (rst) imem_we |-> !run
  ) else $error("imem write while running");

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic                clk,
  input  logic                rst,
  input  cpu_pkg::wb_t        wb,
  input  cpu_pkg::reg_addr_t  read_addr_1,
  input  cpu_pkg::reg_addr_t  read_addr_2,
  output cpu_pkg::data_t      read_data_1,
  output cpu_pkg::data_t      read_data_2
);

  import cpu_pkg::*;

  data_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.dst != '0) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // r0 first, then the write port, then the array
  function automatic data_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wb.valid && wb.dst == addr) begin
      return wb.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    read_data_1 = read_port(read_addr_1);
    read_data_2 = read_port(read_addr_2);
  end

  // execute drops r0 writes before they get here
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (rst) wb.valid |-> wb.dst != '0
  ) else $error("write to r0 reached the register file");

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                clk,
  input  logic                rst,
  input  cpu_pkg::inst_t      if_id_inst,
  output cpu_pkg::reg_addr_t  read_addr_1,
  output cpu_pkg::reg_addr_t  read_addr_2,
  input  cpu_pkg::data_t      read_data_1,
  input  cpu_pkg::data_t      read_data_2,
  output cpu_pkg::id_ex_t     id_ex,
  output logic                stall
);

  import cpu_pkg::*;

  opcode_e   opcode;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      imm;
  ctrl_t     ctrl;
  logic      rs_hazard;
  logic      rt_hazard;

  assign opcode = opcode_e'(if_id_inst[31:26]);
  assign rs     = if_id_inst[25:21];
  assign rt     = if_id_inst[20:16];
  assign rd     = if_id_inst[15:11];
  assign imm    = if_id_inst[15:0];

  assign read_addr_1 = rs;
  assign read_addr_2 = rt;

  ////////////////////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (opcode)
          OP_SUB:  ctrl.alu_op = ALU_SUB;
          OP_AND:  ctrl.alu_op = ALU_AND;
          OP_OR:   ctrl.alu_op = ALU_OR;
          OP_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_ORI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_OR;
        ctrl.reg_write = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      // nop and unknown opcodes
      default: ctrl = '0;
    endcase
  end

  // load in id/ex feeding an operand this instruction actually reads
  assign rs_hazard = uses_rs(ctrl) && id_ex.rt == rs;
  assign rt_hazard = uses_rt(ctrl) && id_ex.rt == rt;
  assign stall     = id_ex.ctrl.mem_read && id_ex.rt != '0 && (rs_hazard || rt_hazard);

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex <= '0;
    end else begin
      id_ex.ctrl        <= stall ? ctrl_t'('0) : ctrl;
      id_ex.rs          <= rs;
      id_ex.rt          <= rt;
      id_ex.rd          <= rd;
      id_ex.read_data_1 <= read_data_1;
      id_ex.read_data_2 <= read_data_2;
      id_ex.imm         <= imm;
    end
  end

  // the bubble clears mem_read, so a stall cannot repeat
  a_single_bubble: assert property (
    @(posedge clk) disable iff (rst) stall |=> !stall
  ) else $error("stall held for two cycles");

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::wb_t      wb,
  output cpu_pkg::ex_mem_t  ex_mem
);

  import cpu_pkg::*;

  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  data_t     operand_a;
  data_t     reg_b;
  data_t     operand_b;
  data_t     alu_result;
  reg_addr_t dst;
  ctrl_t     ctrl_out;

  // ex/mem has priority over mem/wb
  function automatic fwd_sel_e fwd_select(reg_addr_t src);
    if (ex_mem.ctrl.reg_write && ex_mem.dst == src) begin
      return FWD_EX_MEM;
    end else if (wb.valid && wb.dst == src) begin
      return FWD_MEM_WB;
    end
    return FWD_RF;
  endfunction

  function automatic data_t fwd_mux(fwd_sel_e sel, data_t rf_value);
    case (sel)
      FWD_EX_MEM: return ex_mem.alu_result;
      FWD_MEM_WB: return wb.data;
      default:    return rf_value;
    endcase
  endfunction

  always_comb begin
    fwd_a     = fwd_select(id_ex.rs);
    fwd_b     = fwd_select(id_ex.rt);
    operand_a = fwd_mux(fwd_a, id_ex.read_data_1);
    reg_b     = fwd_mux(fwd_b, id_ex.read_data_2);
  end

  // immediates are zero extended
  assign operand_b = id_ex.ctrl.alu_src ? data_t'(id_ex.imm) : reg_b;

  ////////////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_result = operand_a - operand_b;
      ALU_AND: alu_result = operand_a & operand_b;
      ALU_OR:  alu_result = operand_a | operand_b;
      ALU_SLT: alu_result = data_t'($signed(operand_a) < $signed(operand_b));
      default: alu_result = operand_a + operand_b;
    endcase
  end

  assign dst = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

  // r0 writes die here
  always_comb begin
    ctrl_out = id_ex.ctrl;
    if (dst == '0) begin
      ctrl_out.reg_write = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0;
    end else begin
      ex_mem.ctrl       <= ctrl_out;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= reg_b;
      ex_mem.dst        <= dst;
    end
  end

  // decode's load-use stall keeps a load address off the bypass
  a_no_load_forward: assert property (
    @(posedge clk) disable iff (rst)
    ex_mem.ctrl.mem_read |->
      !((uses_rs(id_ex.ctrl) && fwd_a == FWD_EX_MEM) ||
        (uses_rt(id_ex.ctrl) && fwd_b == FWD_EX_MEM))
  ) else $error("load result forwarded from ex/mem");

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage #(
  parameter int DMEM_DEPTH_LOG2 = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::ex_mem_t  ex_mem,
  output cpu_pkg::wb_t      wb
);

  import cpu_pkg::*;

  localparam int DMEM_DEPTH = 2 ** DMEM_DEPTH_LOG2;

  data_t                      dmem [DMEM_DEPTH];
  logic [DMEM_DEPTH_LOG2-1:0] dmem_index;
  data_t                      load_data;

  // mem/wb
  logic      mem_wb_reg_write;
  logic      mem_wb_mem_read;
  reg_addr_t mem_wb_dst;
  data_t     mem_wb_load_data;
  data_t     mem_wb_alu_result;

  assign dmem_index = ex_mem.alu_result[DMEM_DEPTH_LOG2-1:0];
  assign load_data  = dmem[dmem_index];

  always_ff @(posedge clk) begin
    if (ex_mem.ctrl.mem_write) begin
      dmem[dmem_index] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_reg_write <= 1'b0;
      mem_wb_mem_read  <= 1'b0;
    end else begin
      mem_wb_reg_write <= ex_mem.ctrl.reg_write;
      mem_wb_mem_read  <= ex_mem.ctrl.mem_read;
    end
    mem_wb_dst        <= ex_mem.dst;
    mem_wb_load_data  <= load_data;
    mem_wb_alu_result <= ex_mem.alu_result;
  end

  // writeback mux
  assign wb.valid = mem_wb_reg_write;
  assign wb.dst   = mem_wb_dst;
  assign wb.data  = mem_wb_mem_read ? mem_wb_load_data : mem_wb_alu_result;

  a_no_read_write: assert property (
    @(posedge clk) disable iff (rst) !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write)
  ) else $error("data RAM read and write together");

endmodule

/* processor.sv */
`timescale 1ns/1ps

module processor #(
  parameter int IMEM_DEPTH_LOG2 = 6,
  parameter int DMEM_DEPTH_LOG2 = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  logic                imem_we,
  input  cpu_pkg::addr_t      imem_addr,
  input  cpu_pkg::inst_t      imem_data,
  output logic                commit_valid,
  output cpu_pkg::reg_addr_t  commit_reg,
  output cpu_pkg::data_t      commit_data
);

  import cpu_pkg::*;

  inst_t     if_id_inst;
  logic      stall;
  reg_addr_t read_addr_1;
  reg_addr_t read_addr_2;
  data_t     read_data_1;
  data_t     read_data_2;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;

  fetch_stage #(
    .IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .stall      (stall),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .if_id_inst (if_id_inst)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .if_id_inst  (if_id_inst),
    .read_addr_1 (read_addr_1),
    .read_addr_2 (read_addr_2),
    .read_data_1 (read_data_1),
    .read_data_2 (read_data_2),
    .id_ex       (id_ex),
    .stall       (stall)
  );

  register_file u_regfile (
    .clk         (clk),
    .rst         (rst),
    .wb          (wb),
    .read_addr_1 (read_addr_1),
    .read_addr_2 (read_addr_2),
    .read_data_1 (read_data_1),
    .read_data_2 (read_data_2)
  );

  execute_stage u_execute (
    .clk    (clk),
    .rst    (rst),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  memory_stage #(
    .DMEM_DEPTH_LOG2(DMEM_DEPTH_LOG2)
  ) u_memory (
    .clk    (clk),
    .rst    (rst),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

  // every register write shows up on the commit port
  assign commit_valid = wb.valid;
  assign commit_reg   = wb.dst;
  assign commit_data  = wb.data;

endmodule

/* tb_processor.sv */
`timescale 1ns/1ps

module tb_processor;

  import cpu_pkg::*;

  localparam int    IMEM_DEPTH_LOG2 = 6;
  localparam int    DMEM_DEPTH_LOG2 = 6;
  localparam int    IMEM_DEPTH      = 2 ** IMEM_DEPTH_LOG2;
  localparam int    RESET_CYCLES    = 5;
  localparam int    IDLE_CYCLES     = 4;
  localparam int    COMMIT_TIMEOUT  = 40;
  localparam int    QUIET_CYCLES    = 20;
  localparam string GOLDEN_FILE     = "processor_golden.txt";

  logic      clk;
  logic      rst;
  logic      run;
  logic      imem_we;
  addr_t     imem_addr;
  inst_t     imem_data;
  logic      commit_valid;
  reg_addr_t commit_reg;
  data_t     commit_data;

  int          error_count;
  int          check_count;
  logic [31:0] prog_addr [$];
  logic [31:0] prog_inst [$];
  int          exp_group [$];
  logic [31:0] exp_reg [$];
  logic [31:0] exp_data [$];

  processor #(
    .IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2),
    .DMEM_DEPTH_LOG2(DMEM_DEPTH_LOG2)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .commit_valid (commit_valid),
    .commit_reg   (commit_reg),
    .commit_data  (commit_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // inputs change 1 ns after the edge, outputs are settled by then
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string what, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, actual, expected);
    end
  endtask

  // unknown opcode with every register field at r31 for low addresses
  function automatic inst_t fill_word(addr_t a);
    return {6'h3f, 10'h3ff, ~a};
  endfunction

  function automatic string group_name(int group);
    case (group)
      1:       return "quiet during reset and program load";
      2:       return "independent alu ops";
      3:       return "back to back forwarding";
      4:       return "store, load and load-use stall";
      5:       return "r0 writes and reads";
      default: return "no commits from stores, nops and unknown opcodes";
    endcase
  endfunction

  task automatic report_group(input int group, input int errors_before);
    $display("group %0d, %s: %0d errors", group, group_name(group),
             error_count - errors_before);
  endtask

  task automatic write_imem(input addr_t a, input inst_t d);
    imem_we   = 1'b1;
    imem_addr = a;
    imem_data = d;
    step_cycle();
    check("commit_valid while loading", 32'(commit_valid), 32'd0);
  endtask

  task automatic read_golden(output bit ok);
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    ok = 1'b1;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s for reading", GOLDEN_FILE);
      error_count++;
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0) begin
        kind = line.getc(0);
        if (kind == "I") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
          prog_addr.push_back(f1);
          prog_inst.push_back(f2);
        end else if (kind == "W") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
          exp_group.push_back(int'(f1));
          exp_reg.push_back(f2);
          exp_data.push_back(f3);
        end else if (kind != "#" && kind != " " && kind != 8'h0a && kind != 8'h0d) begin
          $display("golden file has a line that is neither I nor W: %s", line);
          error_count++;
          ok = 1'b0;
        end
      end
    end
    $fclose(fd);
    if (exp_reg.size() == 0) begin
      $display("golden file holds no expected commits");
      error_count++;
      ok = 1'b0;
    end
  endtask

  task automatic wait_commit(output bit found);
    found = 1'b0;
    for (int n = 0; n < COMMIT_TIMEOUT && !found; n++) begin
      step_cycle();
      found = commit_valid;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bit loaded;
    bit found;
    int group_errors;
    int last;
    rst         = 1'b1;
    run         = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_data   = '0;
    error_count = 0;
    check_count = 0;
    read_golden(loaded);

    group_errors = error_count;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      step_cycle();
      check("commit_valid during reset", 32'(commit_valid), 32'd0);
    end
    rst = 1'b0;
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      write_imem(addr_t'(a), fill_word(addr_t'(a)));
    end
    for (int i = 0; i < prog_addr.size(); i++) begin
      write_imem(addr_t'(prog_addr[i]), prog_inst[i]);
    end
    imem_we = 1'b0;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      step_cycle();
      check("commit_valid with run low", 32'(commit_valid), 32'd0);
    end
    report_group(1, group_errors);

    if (loaded) begin
      run          = 1'b1;
      found        = 1'b1;
      group_errors = error_count;
      last         = exp_reg.size() - 1;
      for (int i = 0; i <= last && found; i++) begin
        wait_commit(found);
        if (found) begin
          check($sformatf("commit %0d register", i), 32'(commit_reg), exp_reg[i]);
          check($sformatf("commit %0d data", i), commit_data, exp_data[i]);
          if (i < last && exp_group[i + 1] != exp_group[i]) begin
            report_group(exp_group[i], group_errors);
            group_errors = error_count;
          end
        end else begin
          $display("timeout: commit %0d to r%0d did not appear within %0d cycles",
                   i, exp_reg[i], COMMIT_TIMEOUT);
          error_count++;
        end
      end
      // nothing may commit after the last expected write
      if (found) begin
        for (int i = 0; i < QUIET_CYCLES; i++) begin
          step_cycle();
          check("commit_valid after the last commit", 32'(commit_valid), 32'd0);
        end
        report_group(exp_group[last], group_errors);
      end
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* processor_golden.txt */
# I <imem address> <instruction word>, hex
# W <test group> <register> <expected data>, hex, in commit order
I 00 18010015  # addi r1, r0, 0x15
I 01 1c0200f0  # ori  r2, r0, 0xf0
I 02 1803ffff  # addi r3, r0, 0xffff
I 03 1c040007  # ori  r4, r0, 0x7
I 04 04222800  # add  r5, r1, r2
I 05 08833000  # sub  r6, r4, r3
I 06 0c433800  # and  r7, r2, r3
I 07 10244000  # or   r8, r1, r4
I 08 14c14800  # slt  r9, r6, r1
I 09 14265000  # slt  r10, r1, r6
I 0a 180b0005  # addi r11, r0, 5
I 0b 056b6000  # add  r12, r11, r11
I 0c 098b6800  # sub  r13, r12, r11
I 0d 11ac7000  # or   r14, r13, r12
I 0e 19ce0001  # addi r14, r14, 1
I 0f 05cd7800  # add  r15, r14, r13
I 10 240f0008  # sw   r15, 8(r0)
I 11 20100008  # lw   r16, 8(r0)
I 12 06018800  # add  r17, r16, r1
I 13 24030045  # sw   r3, 0x45(r0)
I 14 20120005  # lw   r18, 5(r0)
I 15 0a509800  # sub  r19, r18, r16
I 16 18000063  # addi r0, r0, 0x63
I 17 0401a000  # add  r20, r0, r1
I 18 10220000  # or   r0, r1, r2
I 19 20000008  # lw   r0, 8(r0)
I 1a 0400a800  # add  r21, r0, r0
I 1b 00000000  # nop
I 1c f8221800  # unknown opcode 0x3e
I 1d 24050009  # sw   r5, 9(r0)
I 1e 20160009  # lw   r22, 9(r0)
I 1f 00000000  # nop
I 20 00000000  # nop
W 2 01 00000015
W 2 02 000000f0
W 2 03 0000ffff
W 2 04 00000007
W 2 05 00000105
W 2 06 ffff0008
W 2 07 000000f0
W 2 08 00000017
W 2 09 00000001
W 2 0a 00000000
W 3 0b 00000005
W 3 0c 0000000a
W 3 0d 00000005
W 3 0e 0000000f
W 3 0e 00000010
W 3 0f 00000015
W 4 10 00000015
W 4 11 0000002a
W 4 12 0000ffff
W 4 13 0000ffea
W 5 14 00000015
W 5 15 00000000
W 6 16 00000105

/* sources.f */
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
processor.sv
tb_processor.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_TEXT ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
